//--- calc_top.f
+incdir+src
src/calc_pkg.sv
src/port_capture.sv
src/unit_dispatch.sv
src/add_sub_unit.sv
src/shift_unit.sv
src/resp_router.sv
src/calc_top.sv
test/calc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the calculator testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f calc_top.f --top-module calc_tb \
	&& ./obj_dir/Vcalc_tb > sim.log 2>&1 \
	|| echo "simulator exited with an error status"

[ -f sim.log ] || { echo "no simulation log produced"; exit 1; }
cat sim.log

grep -q '\*\*\* TEST FAILED \*\*\*' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation finished cleanly"
exit 0

//--- test/calc_tb.sv
`timescale 1ns/10ps
`include "calc_cfg.svh"

module calc_tb import calc_pkg::*; ();

	localparam int RESP_TIMEOUT = 20;   // cycles allowed for one response wait

	logic      c_clk;
	logic      rst_n;
	port_in_t  port_in  [`CALC_PORTS];
	port_out_t port_out [`CALC_PORTS];

	integer seed;

	logic [`CALC_PORTS-1:0] live;   // ports that owe a response
	resp_t exp_resp   [`CALC_PORTS];
	data_t exp_data   [`CALC_PORTS];
	int    resp_cycle [`CALC_PORTS];   // cycle of arrival, counted from collect start

	cmd_t  op_cmd [`CALC_PORTS];
	data_t op_a   [`CALC_PORTS];
	data_t op_b   [`CALC_PORTS];

	calc_top dut0 (
		.c_clk    (c_clk),
		.rst_n    (rst_n),
		.port_in  (port_in),
		.port_out (port_out)
	);

	always #4 c_clk = ~c_clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] act,
		input logic [31:0] exp);
		if (act !== exp) begin
			abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, act, exp));
		end
	endtask

	// expected behaviour of one request
	task automatic model(input cmd_t cmd, input data_t a, input data_t b,
		output logic has_resp, output resp_t resp, output data_t data);
		logic [`CALC_DATA_W:0] wide;
		has_resp = 1'b1;
		resp     = `CALC_RESP_OK;
		data     = '0;
		wide     = {1'b0, a} + {1'b0, b};
		case (cmd)
			`CALC_CMD_NOP: has_resp = 1'b0;
			`CALC_CMD_ADD: begin
				if (wide[`CALC_DATA_W]) resp = `CALC_RESP_ERR;   // carry out is overflow
				else data = wide[`CALC_DATA_W-1:0];
			end
			`CALC_CMD_SUB: begin
				if (a < b) resp = `CALC_RESP_ERR;
				else data = a - b;
			end
			`CALC_CMD_SHL: data = a << b[`CALC_SHAMT_W-1:0];
			`CALC_CMD_SHR: data = a >> b[`CALC_SHAMT_W-1:0];
			default: resp = `CALC_RESP_BAD;
		endcase
	endtask

	function automatic data_t rand_data();
		rand_data = $random(seed);
	endfunction

	function automatic cmd_t pick_cmd(input logic [1:0] sel);
		case (sel)
			2'd0: pick_cmd = `CALC_CMD_ADD;
			2'd1: pick_cmd = `CALC_CMD_SUB;
			2'd2: pick_cmd = `CALC_CMD_SHL;
			default: pick_cmd = `CALC_CMD_SHR;
		endcase
	endfunction

	// cmd with op1, then op2, on every port in mask
	task automatic start_ops(input logic [`CALC_PORTS-1:0] mask);
		logic        has;
		logic [31:0] r;
		live = '0;
		@(posedge c_clk);
		#1;
		for (int p = 0; p < `CALC_PORTS; p++) begin
			if (mask[p]) begin
				model(op_cmd[p], op_a[p], op_b[p], has, exp_resp[p], exp_data[p]);
				live[p]    = has;
				port_in[p] = '{cmd: op_cmd[p], data: op_a[p]};
			end
		end
		@(posedge c_clk);
		#1;
		for (int p = 0; p < `CALC_PORTS; p++) begin
			if (mask[p]) begin
				r = $random(seed);
				// junk cmd next to op2, an idle port must still see a no-op
				port_in[p] = '{cmd: live[p] ? r[3:0] : `CALC_CMD_NOP, data: op_b[p]};
			end
		end
		@(posedge c_clk);
		#1;
		for (int p = 0; p < `CALC_PORTS; p++) begin
			port_in[p] = '{cmd: `CALC_CMD_NOP, data: '0};
		end
	endtask

	task automatic expect_quiet(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			@(posedge c_clk);
			#1;
			for (int p = 0; p < `CALC_PORTS; p++) begin
				check_val($sformatf("port_out[%0d].resp", p), 32'(port_out[p].resp), 32'h0);
				check_val($sformatf("port_out[%0d].data", p), port_out[p].data, 32'h0);
			end
		end
	endtask

	task automatic collect_responses();
		logic [`CALC_PORTS-1:0] left;
		int cyc;
		int first;
		left  = live;
		cyc   = 0;
		first = -1;
		while ((left != '0) && (cyc < RESP_TIMEOUT)) begin
			@(posedge c_clk);
			#1;
			cyc++;
			for (int p = 0; p < `CALC_PORTS; p++) begin
				if (port_out[p].resp != `CALC_RESP_NONE) begin
					check_val($sformatf("port_out[%0d] pending", p), 32'(left[p]), 32'd1);
					check_val($sformatf("port_out[%0d].resp", p), 32'(port_out[p].resp),
						32'(exp_resp[p]));
					check_val($sformatf("port_out[%0d].data", p), port_out[p].data, exp_data[p]);
					resp_cycle[p] = cyc;
					left[p]       = 1'b0;
				end else begin
					check_val($sformatf("port_out[%0d].data", p), port_out[p].data, 32'h0);
				end
			end
		end
		if (left != '0) begin
			for (int p = 0; p < `CALC_PORTS; p++) begin
				if (left[p] && (first < 0)) first = p;
			end
			abort_run($sformatf("port %0d never responded within %0d cycles",
				first, RESP_TIMEOUT));
		end
		expect_quiet(1);   // every response is a single-cycle pulse
	endtask

	task automatic run_one(input int p, input cmd_t cmd, input data_t a, input data_t b);
		logic [`CALC_PORTS-1:0] mask;
		mask      = '0;
		mask[p]   = 1'b1;
		op_cmd[p] = cmd;
		op_a[p]   = a;
		op_b[p]   = b;
		start_ops(mask);
		collect_responses();
	endtask

	initial begin
		logic [31:0] r;
		data_t       b;
		seed  = 70;
		c_clk = 1'b0;
		rst_n = 1'b0;
		live  = '0;
		for (int p = 0; p < `CALC_PORTS; p++) begin
			port_in[p] = '{cmd: `CALC_CMD_NOP, data: '0};
			op_cmd[p]  = `CALC_CMD_NOP;
			op_a[p]    = rand_data();
			op_b[p]    = rand_data();
		end
		expect_quiet(16);   // outputs stay silent through reset
		rst_n = 1'b1;
		start_ops('1);   // no-op on every port
		expect_quiet(RESP_TIMEOUT);

		for (int p = 0; p < `CALC_PORTS; p++) begin
			run_one(p, `CALC_CMD_ADD, 32'hffff_ffff, 32'h1);
			run_one(p, `CALC_CMD_ADD, 32'hf0f0_f0f0, 32'h0f0f_0f0f);
			run_one(p, `CALC_CMD_SUB, 32'h1234_5678, 32'h1234_5678);
			run_one(p, `CALC_CMD_SUB, 32'h5, 32'h6);
			for (int n = 0; n < 40; n++) begin
				r = $random(seed);
				b = rand_data();
				if (r[1]) b = b >> 12;   // small op2 so most results are valid
				run_one(p, r[0] ? `CALC_CMD_ADD : `CALC_CMD_SUB, rand_data(), b);
			end
		end

		for (int p = 0; p < `CALC_PORTS; p++) begin
			r = $random(seed);
			run_one(p, `CALC_CMD_SHL, rand_data(), {r[31:5], 5'd0});
			run_one(p, `CALC_CMD_SHR, rand_data(), {r[31:5], 5'd31});
			for (int n = 0; n < 10; n++) begin
				r = $random(seed);
				run_one(p, r[0] ? `CALC_CMD_SHL : `CALC_CMD_SHR, rand_data(), rand_data());
			end
		end

		for (int p = 0; p < `CALC_PORTS; p++) begin
			for (int c = 3; c < 16; c++) begin
				if ((c != 5) && (c != 6)) run_one(p, cmd_t'(c), rand_data(), rand_data());
			end
		end

		// all ports at once, any code including no-op
		for (int n = 0; n < 20; n++) begin
			for (int p = 0; p < `CALC_PORTS; p++) begin
				r         = $random(seed);
				op_cmd[p] = r[2] ? pick_cmd(r[1:0]) : r[7:4];
				op_a[p]   = rand_data();
				op_b[p]   = r[8] ? (rand_data() >> 8) : rand_data();
			end
			start_ops('1);
			collect_responses();
		end

		// same unit contention, lower port always wins
		for (int k = 0; k < 2; k++) begin
			for (int p = 0; p < `CALC_PORTS; p++) begin
				op_cmd[p] = (k == 0) ? `CALC_CMD_ADD : `CALC_CMD_SHL;
				op_a[p]   = 32'h0001_2345;
				op_b[p]   = 32'h3;
			end
			start_ops('1);
			collect_responses();
			for (int p = 1; p < `CALC_PORTS; p++) begin
				check_val($sformatf("response gap port %0d to %0d", p - 1, p),
					32'(resp_cycle[p] - resp_cycle[p-1]), 32'd1);
			end
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- src/calc_top.sv
`timescale 1ns/10ps
`include "calc_cfg.svh"

module calc_top import calc_pkg::*; (
	input  logic      c_clk,
	input  logic      rst_n,
	input  port_in_t  port_in [`CALC_PORTS],
	output port_out_t port_out [`CALC_PORTS]
);

	logic [`CALC_PORTS-1:0] pending;   // capture holds an unissued request
	logic [`CALC_PORTS-1:0] grant;     // one-cycle issue strobe per port
	logic [`CALC_PORTS-1:0] done;      // result delivered to the port

	calc_req_t reqs [`CALC_PORTS];

	unit_in_t  add_in;
	unit_in_t  shift_in;
	unit_res_t add_res;
	unit_res_t shift_res;

	// one capture FSM per port
	for (genvar i = 0; i < `CALC_PORTS; i++) begin : g_port
		port_capture u_cap (
			.c_clk   (c_clk),
			.rst_n   (rst_n),
			.port_in (port_in[i]),
			.grant   (grant[i]),
			.done    (done[i]),
			.pending (pending[i]),
			.req     (reqs[i])
		);
	end

	unit_dispatch u_dispatch (
		.pending  (pending),
		.reqs     (reqs),
		.grant    (grant),
		.add_in   (add_in),
		.shift_in (shift_in)
	);

	add_sub_unit u_add_sub (
		.c_clk (c_clk),
		.rst_n (rst_n),
		.op    (add_in),
		.res   (add_res)
	);

	shift_unit u_shift (
		.c_clk (c_clk),
		.rst_n (rst_n),
		.op    (shift_in),
		.res   (shift_res)
	);

	// results back onto the owning port
	resp_router u_router (
		.c_clk     (c_clk),
		.rst_n     (rst_n),
		.add_res   (add_res),
		.shift_res (shift_res),
		.port_out  (port_out),
		.done      (done)
	);

endmodule

//--- src/resp_router.sv
`timescale 1ns/10ps
`include "calc_cfg.svh"

module resp_router import calc_pkg::*; (
	input  logic                   c_clk,
	input  logic                   rst_n,
	input  unit_res_t              add_res,
	input  unit_res_t              shift_res,
	output port_out_t              port_out [`CALC_PORTS],
	output logic [`CALC_PORTS-1:0] done
);

	port_out_t out_nxt [`CALC_PORTS];

	// one outstanding request per port, so at most one unit hits a port
	always_comb begin
		for (int i = 0; i < `CALC_PORTS; i++) begin
			done[i]    = 1'b0;
			out_nxt[i] = '{resp: `CALC_RESP_NONE, data: '0};
			if (add_res.valid && (add_res.port == port_id_t'(i))) begin
				done[i]    = 1'b1;
				out_nxt[i] = '{resp: add_res.resp, data: add_res.data};
			end
			if (shift_res.valid && (shift_res.port == port_id_t'(i))) begin
				done[i]    = 1'b1;
				out_nxt[i] = '{resp: shift_res.resp, data: shift_res.data};
			end
		end
	end

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CALC_PORTS; i++) begin
				port_out[i] <= '{resp: `CALC_RESP_NONE, data: '0};
			end
		end else begin
			port_out <= out_nxt;   // one-cycle response pulse
		end
	end

endmodule

//--- src/shift_unit.sv
`timescale 1ns/10ps
`include "calc_cfg.svh"

module shift_unit import calc_pkg::*; (
	input  logic      c_clk,
	input  logic      rst_n,
	input  unit_in_t  op,
	output unit_res_t res
);

	logic      s1_valid;
	port_id_t  s1_port;
	calc_req_t s1_req;

	logic      s2_valid;
	port_id_t  s2_port;
	data_t     s2_data;

	shamt_t    shamt;

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= op.valid;
			s2_valid <= s1_valid;
		end
	end

	assign shamt = s1_req.op2[`CALC_SHAMT_W-1:0];   // upper op2 bits ignored

	always_ff @(posedge c_clk) begin
		if (op.valid) begin
			s1_port <= op.port;
			s1_req  <= op.req;
		end
		if (s1_valid) begin
			s2_port <= s1_port;
			// logical shifts, dispatcher only sends SHL and SHR here
			s2_data <= (s1_req.cmd == `CALC_CMD_SHL) ? (s1_req.op1 << shamt)
				: (s1_req.op1 >> shamt);
		end
	end

	assign res = '{valid: s2_valid, port: s2_port, resp: `CALC_RESP_OK, data: s2_data};

endmodule

//--- src/add_sub_unit.sv
`timescale 1ns/10ps
`include "calc_cfg.svh"

module add_sub_unit import calc_pkg::*; (
	input  logic      c_clk,
	input  logic      rst_n,
	input  unit_in_t  op,
	output unit_res_t res
);

	logic      s1_valid;
	port_id_t  s1_port;
	calc_req_t s1_req;

	logic      s2_valid;
	port_id_t  s2_port;
	resp_t     s2_resp;
	data_t     s2_data;

	logic [`CALC_DATA_W:0] sum;   // top bit is the carry out
	data_t     diff;
	resp_t     resp_nxt;
	data_t     data_nxt;

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= op.valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge c_clk) begin
		if (op.valid) begin
			s1_port <= op.port;
			s1_req  <= op.req;
		end
		if (s1_valid) begin
			s2_port <= s1_port;
			s2_resp <= resp_nxt;
			s2_data <= data_nxt;
		end
	end

	assign sum  = {1'b0, s1_req.op1} + {1'b0, s1_req.op2};
	assign diff = s1_req.op1 - s1_req.op2;

	// stage 2 result, error codes carry zero data
	always_comb begin
		resp_nxt = `CALC_RESP_BAD;
		data_nxt = '0;
		case (s1_req.cmd)
			`CALC_CMD_ADD: begin
				resp_nxt = sum[`CALC_DATA_W] ? `CALC_RESP_ERR : `CALC_RESP_OK;
				data_nxt = sum[`CALC_DATA_W] ? '0 : sum[`CALC_DATA_W-1:0];
			end
			`CALC_CMD_SUB: begin
				resp_nxt = (s1_req.op1 < s1_req.op2) ? `CALC_RESP_ERR : `CALC_RESP_OK;
				data_nxt = (s1_req.op1 < s1_req.op2) ? '0 : diff;
			end
			default: begin
			end
		endcase
	end

	assign res = '{valid: s2_valid, port: s2_port, resp: s2_resp, data: s2_data};

endmodule

//--- src/unit_dispatch.sv
`timescale 1ns/10ps
`include "calc_cfg.svh"

module unit_dispatch import calc_pkg::*; (
	input  logic [`CALC_PORTS-1:0] pending,
	input  calc_req_t              reqs [`CALC_PORTS],
	output logic [`CALC_PORTS-1:0] grant,
	output unit_in_t               add_in,
	output unit_in_t               shift_in
);

	logic [`CALC_PORTS-1:0] want_shift;
	logic [`CALC_PORTS-1:0] want_add;     // add, sub and invalid codes
	logic [`CALC_PORTS-1:0] grant_add;
	logic [`CALC_PORTS-1:0] grant_shift;

	// sort pending requests by execution unit
	always_comb begin
		for (int i = 0; i < `CALC_PORTS; i++) begin
			want_shift[i] = pending[i] &&
				((reqs[i].cmd == `CALC_CMD_SHL) || (reqs[i].cmd == `CALC_CMD_SHR));
			want_add[i] = pending[i] && !want_shift[i];
		end
	end

	// per unit, lowest pending port wins
	always_comb begin
		add_in      = '0;
		shift_in    = '0;
		grant_add   = '0;
		grant_shift = '0;
		for (int i = 0; i < `CALC_PORTS; i++) begin
			if (want_add[i] && !add_in.valid) begin
				grant_add[i] = 1'b1;
				add_in.valid = 1'b1;
				add_in.port  = port_id_t'(i);
				add_in.req   = reqs[i];
			end
			if (want_shift[i] && !shift_in.valid) begin
				grant_shift[i] = 1'b1;
				shift_in.valid = 1'b1;
				shift_in.port  = port_id_t'(i);
				shift_in.req   = reqs[i];
			end
		end
	end

	// a port wants only one unit, so the two grant vectors never overlap
	assign grant = grant_add | grant_shift;

endmodule

//--- src/port_capture.sv
`timescale 1ns/10ps
`include "calc_cfg.svh"

module port_capture import calc_pkg::*; (
	input  logic      c_clk,
	input  logic      rst_n,
	input  port_in_t  port_in,
	input  logic      grant,
	input  logic      done,
	output logic      pending,
	output calc_req_t req
);

	cap_state_e state;
	logic       issued;   // sent to a unit, result not back yet
	logic       start;

	// only an idle port takes a new command
	assign start = (state == cap_idle) && (port_in.cmd != `CALC_CMD_NOP);

	assign pending = (state == cap_pending) && !issued;

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= cap_idle;
			issued <= 1'b0;
		end else begin
			case (state)
				cap_idle: begin
					if (start) begin
						state <= cap_wait_op2;
					end
				end
				cap_wait_op2: begin
					state  <= cap_pending;   // op2 is on the bus this cycle
					issued <= 1'b0;
				end
				cap_pending: begin
					if (grant) begin
						issued <= 1'b1;
					end
					// router pulse ends the transaction
					if (done) begin
						state  <= cap_idle;
						issued <= 1'b0;
					end
				end
				default: begin
					state <= cap_idle;
				end
			endcase
		end
	end

	always_ff @(posedge c_clk) begin
		if (start) begin
			req.cmd <= port_in.cmd;
			req.op1 <= port_in.data;
		end
		if (state == cap_wait_op2) begin
			req.op2 <= port_in.data;   // cmd in this cycle is ignored
		end
	end

endmodule

//--- src/calc_pkg.sv
`include "calc_cfg.svh"

package calc_pkg;

	typedef logic [`CALC_DATA_W-1:0]         data_t;
	typedef logic [`CALC_CMD_W-1:0]          cmd_t;
	typedef logic [`CALC_RESP_W-1:0]         resp_t;
	typedef logic [$clog2(`CALC_PORTS)-1:0]  port_id_t;
	typedef logic [`CALC_SHAMT_W-1:0]        shamt_t;

	// per-port capture states
	typedef enum logic [1:0] {
		cap_idle,
		cap_wait_op2,   // cmd and op1 taken, op2 due this cycle
		cap_pending     // full request held until its result returns
	} cap_state_e;

	typedef struct packed {
		cmd_t  cmd;
		data_t data;
	} port_in_t;

	typedef struct packed {
		resp_t resp;
		data_t data;
	} port_out_t;

	typedef struct packed {
		cmd_t  cmd;
		data_t op1;
		data_t op2;
	} calc_req_t;

	// operation issued to an execution unit
	typedef struct packed {
		logic      valid;
		port_id_t  port;
		calc_req_t req;
	} unit_in_t;

	// result leaving an execution unit
	typedef struct packed {
		logic     valid;
		port_id_t port;
		resp_t    resp;
		data_t    data;
	} unit_res_t;

endpackage

//--- src/calc_cfg.svh
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// datapath widths
`define CALC_DATA_W  32
`define CALC_CMD_W   4
`define CALC_RESP_W  2
`define CALC_SHAMT_W 5   // low bits of operand 2 used by shifts

// number of request ports
`define CALC_PORTS   4

// command codes
`define CALC_CMD_NOP 4'd0
`define CALC_CMD_ADD 4'd1
`define CALC_CMD_SUB 4'd2
`define CALC_CMD_SHL 4'd5
`define CALC_CMD_SHR 4'd6

// response codes
`define CALC_RESP_NONE 2'd0
`define CALC_RESP_OK   2'd1   // data valid
`define CALC_RESP_ERR  2'd2   // overflow or underflow
`define CALC_RESP_BAD  2'd3   // invalid command

`endif
